/* cdma_config.svh */
// Widths and sizes of the read DMA channel, included by the RTL and the testbench
`ifndef CDMA_CONFIG_SVH
`define CDMA_CONFIG_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

// Byte address
`define CDMA_ADDR_BITS      32
// One beat is 8 bytes
`define CDMA_DATA_BITS      64
// Descriptor length in beats
`define CDMA_LEN_BITS       16

//////////////////////////////////////////////////
// Burst shaping and queues
//////////////////////////////////////////////////

// Max beats per read burst
`define CDMA_BURST_LEN      16
// Page that no burst may cross
`define CDMA_BOUNDARY_BYTES 4096

// Depth of descriptor and sequence queues
// Also bounds descriptors in flight
`define CDMA_QUEUE_DEPTH    4

`endif

/* cdma_desc_pkg.sv */
// Descriptor-side types, imported by the controller, the data path and the testbench
`include "cdma_config.svh"

package cdma_desc_pkg;

  // Beat count as carried by a descriptor
  typedef logic [`CDMA_LEN_BITS-1:0] cdma_len_t;

  // Read request from the requester
  // 49 bits, one queue word
  typedef struct packed {
    logic [`CDMA_ADDR_BITS-1:0] paddr;
    cdma_len_t                  len;
    logic                       last;
  } cdma_desc_t;

  // Record per accepted descriptor
  // Travels from the controller to the data side
  typedef struct packed {
    cdma_len_t len;
    // Sequence end, gates tlast and done
    logic      last;
  } cdma_seq_t;

endpackage

/* cdma_axi_pkg.sv */
// Memory read channel types for the AR and R sides, imported by RTL and testbench
package cdma_axi_pkg;

  // Burst length field
  // Beats minus one, as on AXI
  typedef logic [7:0] axi_len_t;

  // Read response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_t;

endpackage

/* cdma_fifo.sv */
// Synchronous valid/ready FIFO, instantiated for the descriptor and sequence queues
`timescale 1ns/100ps

module cdma_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             aclk,
  input  logic             reset,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  // Register array and its bookkeeping
  logic [WIDTH-1:0]    mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                push;
  logic                pop;

  // Step with wrap for any depth
  function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready  = (count != CNT_BITS'(DEPTH));
  assign out_valid = (count != '0);
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  // Head word straight from the registers
  assign out_data  = mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // Simultaneous push and pop leaves count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Full and empty both mean the pointers meet
  a_full_ptrs_meet: assert property (@(posedge aclk) disable iff (reset)
    (count == CNT_BITS'(DEPTH)) |-> (wr_ptr == rd_ptr));
  a_empty_ptrs_meet: assert property (@(posedge aclk) disable iff (reset)
    (count == '0) |-> (wr_ptr == rd_ptr));

endmodule

/* cdma_beat_counter.sv */
// Beat counter for the head descriptor, used by the read data path to find its final beat
`timescale 1ns/100ps

module cdma_beat_counter
  import cdma_desc_pkg::*;
(
  input  logic      aclk,
  input  logic      reset,
  // Length of the head descriptor
  input  cdma_len_t seq_len,
  // Output beat transferred
  input  logic      beat,
  output logic      final_beat
);

  // Beats of the head descriptor already sent
  cdma_len_t count;

  assign final_beat = (count == cdma_len_t'(seq_len - 1'b1));

  always_ff @(posedge aclk) begin
    if (reset) begin
      count <= '0;
    end else if (beat) begin
      // Restart for the next descriptor
      if (final_beat) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // Counter never runs past the head record
  a_count_bound: assert property (@(posedge aclk) disable iff (reset)
    beat |-> (count < seq_len));

endmodule

/* cdma_rd_ctrl.sv */
// Read control FSM, splits queued descriptors into bursts and feeds the sequence queue
`timescale 1ns/100ps
`include "cdma_config.svh"

module cdma_rd_ctrl
  import cdma_desc_pkg::*, cdma_axi_pkg::*;
(
  input  logic                       aclk,
  input  logic                       reset,
  // Descriptor queue head
  input  logic                       desc_valid,
  output logic                       desc_ready,
  input  cdma_desc_t                 desc_data,
  // Record to the data side
  output logic                       seq_valid,
  input  logic                       seq_ready,
  output cdma_seq_t                  seq_data,
  // Read address channel
  output logic                       ar_valid,
  input  logic                       ar_ready,
  output logic [`CDMA_ADDR_BITS-1:0] ar_addr,
  output axi_len_t                   ar_len
);

  localparam int ADDR_BITS  = `CDMA_ADDR_BITS;
  localparam int BEAT_BYTES = `CDMA_DATA_BITS / 8;
  localparam int BND_BITS   = $clog2(`CDMA_BOUNDARY_BYTES);

  typedef enum logic [1:0] {IDLE, LOAD, ISSUE, WAIT_AR} state_t;

  state_t                 state;
  // Start of the next burst and beats not yet requested
  logic [ADDR_BITS-1:0]   cur_addr;
  cdma_len_t              rem_len;
  cdma_len_t              burst;
  logic                   issue;

  //////////////////////////////////////////////////
  // Burst sizing
  //////////////////////////////////////////////////

  // Smallest of remaining beats, max burst and room to the page end
  function automatic cdma_len_t burst_beats(
    input logic [ADDR_BITS-1:0] addr,
    input cdma_len_t            rem
  );
    logic [BND_BITS:0] to_bnd;
    cdma_len_t         room;
    cdma_len_t         beats;
    to_bnd = (BND_BITS + 1)'(`CDMA_BOUNDARY_BYTES) - {1'b0, addr[BND_BITS-1:0]};
    room   = cdma_len_t'(to_bnd / BEAT_BYTES);
    beats  = rem;
    if (beats > cdma_len_t'(`CDMA_BURST_LEN)) begin
      beats = cdma_len_t'(`CDMA_BURST_LEN);
    end
    if (beats > room) begin
      beats = room;
    end
    return beats;
  endfunction

  assign burst = burst_beats(cur_addr, rem_len);

  // First burst from ISSUE, the rest back to back from WAIT_AR
  assign issue = (state == ISSUE) ||
                 ((state == WAIT_AR) && ar_ready && (rem_len != '0));

  //////////////////////////////////////////////////
  // Descriptor load
  //////////////////////////////////////////////////

  // Descriptor pop and record push go together
  assign desc_ready = (state == LOAD) && seq_ready;
  assign seq_valid  = (state == LOAD) && desc_valid;
  assign seq_data   = '{len: desc_data.len, last: desc_data.last};

  always_ff @(posedge aclk) begin
    if (reset) begin
      state    <= IDLE;
      ar_valid <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (desc_valid) begin
            state <= LOAD;
          end
        end
        // Parks here while the sequence queue is full
        LOAD: begin
          if (desc_valid && desc_ready) begin
            state <= ISSUE;
          end
        end
        ISSUE: begin
          ar_valid <= 1'b1;
          state    <= WAIT_AR;
        end
        WAIT_AR: begin
          if (ar_ready && (rem_len == '0)) begin
            ar_valid <= 1'b0;
            state    <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Address walk and burst fields
  always_ff @(posedge aclk) begin
    if (desc_valid && desc_ready) begin
      cur_addr <= desc_data.paddr;
      rem_len  <= desc_data.len;
    end else if (issue) begin
      ar_addr  <= cur_addr;
      ar_len   <= axi_len_t'(burst - 1'b1);
      cur_addr <= cur_addr + ADDR_BITS'(BEAT_BYTES * burst);
      rem_len  <= rem_len - burst;
    end
  end

  // Zero length would wrap ar_len to 255
  a_len_nonzero: assert property (@(posedge aclk) disable iff (reset)
    (desc_valid && desc_ready) |-> (desc_data.len != '0));
  // Every burst fits its page and the max length
  a_no_cross: assert property (@(posedge aclk) disable iff (reset)
    ar_valid |-> ((int'(ar_addr[BND_BITS-1:0]) + (int'(ar_len) + 1) * BEAT_BYTES
                   <= `CDMA_BOUNDARY_BYTES) && (int'(ar_len) < `CDMA_BURST_LEN)));

endmodule

/* cdma_rd_stream.sv */
// Read data path from the R channel to the output stream, with tlast, done and error status
`timescale 1ns/100ps
`include "cdma_config.svh"

module cdma_rd_stream
  import cdma_desc_pkg::*, cdma_axi_pkg::*;
(
  input  logic                       aclk,
  input  logic                       reset,
  // Memory read data
  input  logic                       r_valid,
  output logic                       r_ready,
  input  logic [`CDMA_DATA_BITS-1:0] r_data,
  input  axi_resp_t                  r_resp,
  input  logic                       r_last,
  // Head of the sequence queue
  input  logic                       seq_valid,
  output logic                       seq_ready,
  input  cdma_seq_t                  seq_data,
  // Output stream
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,
  output logic [`CDMA_DATA_BITS-1:0] m_axis_tdata,
  output logic                       m_axis_tlast,
  // Status
  output logic                       rd_done,
  output logic                       rd_error
);

  logic r_take;
  logic beat;
  logic final_beat;
  // Held beat closed its R burst
  logic burst_end;

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  assign beat    = m_axis_tvalid && m_axis_tready;
  // Accept when empty or draining this cycle
  assign r_ready = !m_axis_tvalid || m_axis_tready;
  assign r_take  = r_valid && r_ready;

  always_ff @(posedge aclk) begin
    if (reset) begin
      m_axis_tvalid <= 1'b0;
      rd_done       <= 1'b0;
      rd_error      <= 1'b0;
    end else begin
      if (r_take) begin
        m_axis_tvalid <= 1'b1;
      end else if (beat) begin
        m_axis_tvalid <= 1'b0;
      end
      // One cycle after the last beat of a sequence end
      rd_done <= seq_ready && seq_data.last;
      // Sticky, beat itself still goes out
      if (r_take && (r_resp != OKAY)) begin
        rd_error <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (r_take) begin
      m_axis_tdata <= r_data;
      burst_end    <= r_last;
    end
  end

  //////////////////////////////////////////////////
  // Sequence tracking
  //////////////////////////////////////////////////

  cdma_beat_counter beat_counter_inst (
    .aclk       (aclk),
    .reset      (reset),
    .seq_len    (seq_data.len),
    .beat       (beat),
    .final_beat (final_beat)
  );

  // Pop the record as its final beat leaves
  assign seq_ready    = beat && final_beat;
  assign m_axis_tlast = m_axis_tvalid && final_beat && seq_data.last;

  // Record pushed before any of its data can return
  a_seq_present: assert property (@(posedge aclk) disable iff (reset)
    m_axis_tvalid |-> seq_valid);
  // Descriptor end lines up with a burst end from the controller
  a_desc_end_burst: assert property (@(posedge aclk) disable iff (reset)
    (m_axis_tvalid && final_beat) |-> burst_end);

endmodule

/* cdma_rd_top.sv */
// Top level of the read DMA channel, wires the queues, the controller and the data path
`timescale 1ns/100ps
`include "cdma_config.svh"

module cdma_rd_top
  import cdma_desc_pkg::*, cdma_axi_pkg::*;
(
  input  logic                       aclk,
  input  logic                       reset,
  // Descriptor in
  input  logic                       desc_valid,
  output logic                       desc_ready,
  input  cdma_desc_t                 desc_data,
  // Read address out
  output logic                       ar_valid,
  input  logic                       ar_ready,
  output logic [`CDMA_ADDR_BITS-1:0] ar_addr,
  output axi_len_t                   ar_len,
  // Read data in
  input  logic                       r_valid,
  output logic                       r_ready,
  input  logic [`CDMA_DATA_BITS-1:0] r_data,
  input  axi_resp_t                  r_resp,
  input  logic                       r_last,
  // Stream out
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,
  output logic [`CDMA_DATA_BITS-1:0] m_axis_tdata,
  output logic                       m_axis_tlast,
  // Status
  output logic                       rd_done,
  output logic                       rd_error
);

  // Queued descriptor to the controller
  logic       q_desc_valid;
  logic       q_desc_ready;
  cdma_desc_t q_desc_data;
  // Controller into the sequence queue
  logic       seq_in_valid;
  logic       seq_in_ready;
  cdma_seq_t  seq_in_data;
  // Sequence queue head to the data path
  logic       seq_out_valid;
  logic       seq_out_ready;
  cdma_seq_t  seq_out_data;

  //////////////////////////////////////////////////
  // Queues
  //////////////////////////////////////////////////

  cdma_fifo #(
    .WIDTH ($bits(cdma_desc_t)),
    .DEPTH (`CDMA_QUEUE_DEPTH)
  ) desc_fifo_inst (
    .aclk      (aclk),
    .reset     (reset),
    .in_valid  (desc_valid),
    .in_ready  (desc_ready),
    .in_data   (desc_data),
    .out_valid (q_desc_valid),
    .out_ready (q_desc_ready),
    .out_data  (q_desc_data)
  );

  // Popped by the data path on each final beat
  cdma_fifo #(
    .WIDTH ($bits(cdma_seq_t)),
    .DEPTH (`CDMA_QUEUE_DEPTH)
  ) seq_fifo_inst (
    .aclk      (aclk),
    .reset     (reset),
    .in_valid  (seq_in_valid),
    .in_ready  (seq_in_ready),
    .in_data   (seq_in_data),
    .out_valid (seq_out_valid),
    .out_ready (seq_out_ready),
    .out_data  (seq_out_data)
  );

  //////////////////////////////////////////////////
  // Control and data
  //////////////////////////////////////////////////

  cdma_rd_ctrl rd_ctrl_inst (
    .aclk       (aclk),
    .reset      (reset),
    .desc_valid (q_desc_valid),
    .desc_ready (q_desc_ready),
    .desc_data  (q_desc_data),
    .seq_valid  (seq_in_valid),
    .seq_ready  (seq_in_ready),
    .seq_data   (seq_in_data),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .ar_addr    (ar_addr),
    .ar_len     (ar_len)
  );

  cdma_rd_stream rd_stream_inst (
    .aclk          (aclk),
    .reset         (reset),
    .r_valid       (r_valid),
    .r_ready       (r_ready),
    .r_data        (r_data),
    .r_resp        (r_resp),
    .r_last        (r_last),
    .seq_valid     (seq_out_valid),
    .seq_ready     (seq_out_ready),
    .seq_data      (seq_out_data),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast),
    .rd_done       (rd_done),
    .rd_error      (rd_error)
  );

endmodule

/* cdma_tb.sv */
// Testbench for the read DMA channel, runs the descriptors from cdma_testdata.txt
`timescale 1ns/100ps
`include "cdma_config.svh"

module cdma_tb
  import cdma_desc_pkg::*, cdma_axi_pkg::*;
();

  logic                       aclk;
  logic                       reset;
  logic                       desc_valid;
  logic                       desc_ready;
  cdma_desc_t                 desc_data;
  logic                       ar_valid;
  logic                       ar_ready;
  logic [`CDMA_ADDR_BITS-1:0] ar_addr;
  axi_len_t                   ar_len;
  logic                       r_valid;
  logic                       r_ready;
  logic [`CDMA_DATA_BITS-1:0] r_data;
  axi_resp_t                  r_resp;
  logic                       r_last;
  logic                       m_axis_tvalid;
  logic                       m_axis_tready;
  logic [`CDMA_DATA_BITS-1:0] m_axis_tdata;
  logic                       m_axis_tlast;
  logic                       rd_done;
  logic                       rd_error;

  // Descriptors and expected totals from the data file
  logic [31:0] d_addr [$];
  int          d_len [$];
  bit          d_last [$];
  logic [31:0] err_lo;
  logic [31:0] err_hi;
  int          exp_beats;
  int          exp_seq_ends;
  int          exp_error;
  bit          loaded = 0;

  // Handshakes seen at the falling edge for the next drive
  bit desc_fire = 0;
  bit ar_fire = 0;
  bit r_fire = 0;

  // Memory model state
  logic [31:0] rq_addr [$];
  int          rq_beats [$];
  logic [31:0] r_next_addr;
  logic [31:0] r_beat_addr;
  int          r_left = 0;
  logic [15:0] lfsr;

  // Scoreboard state
  int          desc_idx = 0;
  int          ar_idx = 0;
  int          ar_left = 0;
  logic [31:0] ar_exp;
  int          out_idx = 0;
  int          out_left = 0;
  logic [31:0] out_addr;
  bit          err_model = 0;
  int          beats_seen = 0;
  int          last_count = 0;
  int          done_count = 0;
  int          desc_err_start = 0;
  int          tests = 0;
  int          checks = 0;
  int          errors = 0;
  int          cycle = 0;

  cdma_rd_top cdma_rd_top_inst (.*);

  always #4 aclk = ~aclk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic lfsr_bit();
    logic fb;
    // Taps 16 14 13 11
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic bit in_err_range(input logic [31:0] addr);
    return (addr >= err_lo) && (addr <= err_hi);
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic read_testdata();
    int          fd;
    int          n;
    string       line;
    byte         tag;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    fd = $fopen("cdma_testdata.txt", "r");
    if (fd == 0) begin
      $display("Could not open cdma_testdata.txt");
      $display("*** FAILED ***");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        // Skip comments and blank lines
        if (n > 0 && line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h %h", tag, a, b, c);
          if (tag == "D") begin
            d_addr.push_back(a);
            d_len.push_back(int'(b));
            d_last.push_back(c[0]);
          end else if (tag == "E") begin
            err_lo = a;
            err_hi = b;
          end else if (tag == "T") begin
            exp_beats    = int'(a);
            exp_seq_ends = int'(b);
            exp_error    = int'(c);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////
  // Drivers 1 ns after the rising edge
  //////////////////////////////////////////////////

  task automatic drive_read_data();
    // Free the channel once the presented beat is taken
    if (r_fire) begin
      r_valid = 1'b0;
      r_last  = 1'b0;
    end
    if (!r_valid) begin
      if (r_left == 0 && rq_addr.size() > 0) begin
        r_next_addr = rq_addr.pop_front();
        r_left      = rq_beats.pop_front();
      end
      // Random gaps in about one cycle of four
      if (r_left != 0 && (lfsr_bit() || lfsr_bit())) begin
        r_beat_addr = r_next_addr;
        r_data      = {r_next_addr, ~r_next_addr};
        r_resp      = in_err_range(r_next_addr) ? SLVERR : OKAY;
        r_last      = (r_left == 1);
        r_valid     = 1'b1;
        r_next_addr = r_next_addr + 32'd8;
        r_left--;
      end
    end
  endtask

  always @(posedge aclk) begin
    #1;
    cycle++;
    if (cycle == 5) begin
      reset = 1'b0;
    end else if (cycle > 5) begin
      // Descriptor held until taken
      if (desc_fire) begin
        desc_idx++;
      end
      desc_valid = (desc_idx < d_addr.size());
      if (desc_valid) begin
        desc_data.paddr = d_addr[desc_idx];
        desc_data.len   = cdma_len_t'(d_len[desc_idx]);
        desc_data.last  = d_last[desc_idx];
      end
      ar_ready = lfsr_bit();
      drive_read_data();
      m_axis_tready = lfsr_bit() || lfsr_bit();
    end
  end

  //////////////////////////////////////////////////
  // Monitors at the falling edge
  //////////////////////////////////////////////////

  task automatic observe_ar();
    int beats;
    beats = int'(ar_len) + 1;
    if (ar_left == 0) begin
      if (ar_idx >= d_addr.size()) begin
        errors++;
        $display("AR at %h was issued with no descriptor left", ar_addr);
        return;
      end
      ar_exp  = d_addr[ar_idx];
      ar_left = d_len[ar_idx];
      ar_idx++;
    end
    // Bursts of one descriptor must be contiguous
    check_value("ar_addr", ar_addr, ar_exp);
    if (beats > `CDMA_BURST_LEN) begin
      errors++;
      $display("AR burst at %h has %0d beats, above the maximum", ar_addr, beats);
    end
    if (int'(ar_addr % `CDMA_BOUNDARY_BYTES) + beats * 8 > `CDMA_BOUNDARY_BYTES) begin
      errors++;
      $display("AR burst at %h with %0d beats crosses a 4 KB page", ar_addr, beats);
    end
    if (beats > ar_left) begin
      errors++;
      $display("AR burst at %h runs past the end of its descriptor", ar_addr);
    end
    ar_exp  = ar_exp + 32'(beats * 8);
    ar_left = ar_left - beats;
    rq_addr.push_back(ar_addr);
    rq_beats.push_back(beats);
  endtask

  task automatic observe_beat();
    logic [63:0] exp_data;
    logic        exp_last;
    beats_seen++;
    if (out_left == 0) begin
      if (out_idx >= d_addr.size()) begin
        errors++;
        $display("Output beat %h arrived after every descriptor was complete", m_axis_tdata);
        return;
      end
      out_addr = d_addr[out_idx];
      out_left = d_len[out_idx];
    end
    exp_data = {out_addr, ~out_addr};
    exp_last = (out_left == 1) && d_last[out_idx];
    check_value("m_axis_tdata", m_axis_tdata, exp_data);
    check_value("m_axis_tlast", m_axis_tlast, exp_last);
    // Error beats still carry good data
    if (in_err_range(out_addr)) begin
      check_value("rd_error", rd_error, 1);
    end
    if (m_axis_tlast) begin
      last_count++;
    end
    out_addr = out_addr + 32'd8;
    out_left--;
    if (out_left == 0) begin
      $display("desc %0d addr %h len %0d last %0d: %s", out_idx, d_addr[out_idx],
               d_len[out_idx], d_last[out_idx], (errors == desc_err_start) ? "ok" : "errors");
      tests++;
      out_idx++;
      desc_err_start = errors;
    end
  endtask

  always @(negedge aclk) begin
    desc_fire = desc_valid && desc_ready;
    ar_fire   = ar_valid && ar_ready;
    r_fire    = r_valid && r_ready;
    if (!reset) begin
      // Sticky flag follows the first non-OKAY R beat
      check_value("rd_error", rd_error, err_model);
      // A pulse needs a last beat that has already transferred
      if (rd_done) begin
        if (done_count >= last_count) begin
          errors++;
          $display("rd_done pulsed before its descriptor's last beat transferred");
        end
        done_count++;
      end
      if (ar_fire) begin
        observe_ar();
      end
      if (r_fire && in_err_range(r_beat_addr)) begin
        err_model = 1'b1;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        observe_beat();
      end
    end
  end

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  initial begin
    aclk          = 1'b0;
    reset         = 1'b1;
    desc_valid    = 1'b0;
    desc_data     = '0;
    ar_ready      = 1'b0;
    r_valid       = 1'b0;
    r_data        = '0;
    r_resp        = OKAY;
    r_last        = 1'b0;
    m_axis_tready = 1'b0;
    lfsr          = 16'd30;
    read_testdata();
    loaded = 1'b1;
    wait (beats_seen >= exp_beats && done_count >= exp_seq_ends);
    // Room for stray beats or pulses
    repeat (20) @(posedge aclk);
    desc_err_start = errors;
    check_value("beat_total", beats_seen, exp_beats);
    check_value("tlast_total", last_count, exp_seq_ends);
    check_value("done_total", done_count, exp_seq_ends);
    check_value("rd_error", rd_error, exp_error);
    check_value("ar_desc_count", ar_idx, d_addr.size());
    check_value("ar_beats_left", ar_left, 0);
    tests++;
    $display("totals beats %0d lasts %0d dones %0d: %s", beats_seen, last_count, done_count,
             (errors == desc_err_start) ? "ok" : "errors");
    $display("tests %0d checks %0d errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog scaled by the expected beat count
  initial begin
    wait (loaded);
    repeat (exp_beats * 8 + 2000) @(posedge aclk);
    $display("Timeout: the run did not finish within %0d cycles", exp_beats * 8 + 2000);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* cdma_testdata.txt */
# D <addr> <len in beats> <sequence end>   read descriptor, in order
# E <first addr> <last addr>               beats answered with SLVERR
# T <beats> <sequence ends> <error flag>   expected totals
# All values are hex
D 00001000 0005 0
D 00001028 0028 1
D 00001FC0 0014 1
D 00003000 0001 1
D 00003FF8 0003 0
D 00004100 0020 0
D 00005F80 0030 1
D 0000A000 0002 1
D 0000BFE8 0007 1
D 00010000 0011 1
E 00005FA0 00005FB8
T 000000AF 00000007 00000001

/* sim.f */
+incdir+.
cdma_desc_pkg.sv
cdma_axi_pkg.sv
cdma_fifo.sv
cdma_beat_counter.sv
cdma_rd_ctrl.sv
cdma_rd_stream.sv
cdma_rd_top.sv
cdma_tb.sv
